// File: rtl/armPkg.sv
package armPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] regAddr_t;

    // the PC shows up as register 15
    localparam regAddr_t regPc = 4'd15;

    typedef struct packed {
        logic neg;
        logic zero;
        logic carry;
        logic overflow;
    } aluFlags_t;

    // instr[27:26]
    localparam logic [1:0] opDataProc = 2'b00;
    localparam logic [1:0] opMemory   = 2'b01;
    localparam logic [1:0] opBranch   = 2'b10;

    // data processing cmd field, instr[24:21]
    localparam logic [3:0] cmdAnd = 4'b0000;
    localparam logic [3:0] cmdEor = 4'b0001;
    localparam logic [3:0] cmdSub = 4'b0010;
    localparam logic [3:0] cmdAdd = 4'b0100;
    localparam logic [3:0] cmdOrr = 4'b1100;

    localparam logic [3:0] mulPattern = 4'b1001; // instr[7:4] of MUL

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOrr = 3'd3,
        aluEor = 3'd4,
        aluMul = 3'd5
    } aluOp_e;

    typedef enum logic [3:0] {
        condEq = 4'h0,
        condNe = 4'h1,
        condCs = 4'h2,
        condCc = 4'h3,
        condMi = 4'h4,
        condPl = 4'h5,
        condVs = 4'h6,
        condVc = 4'h7,
        condHi = 4'h8,
        condLs = 4'h9,
        condGe = 4'ha,
        condLt = 4'hb,
        condGt = 4'hc,
        condLe = 4'hd,
        condAl = 4'he
    } cond_e;

    typedef enum logic [3:0] {
        stFetch    = 4'd0,
        stDecode   = 4'd1,
        stMemAdr   = 4'd2,
        stMemRd    = 4'd3,
        stMemWb    = 4'd4,
        stMemWr    = 4'd5,
        stExecuteR = 4'd6,
        stExecuteI = 4'd7,
        stAluWb    = 4'd8,
        stBranch   = 4'd9
    } fsmState_e;

    typedef struct packed {
        logic       irWrite;
        logic       adrSrc;    // 1 = result drives the bus address
        logic [1:0] resultSrc; // aluOut, data, aluResult
        logic       aluSrcA;   // 1 = PC
        logic [1:0] aluSrcB;   // reg, imm, 4
        logic [1:0] immSrc;
        logic [1:0] regSrc;
        aluOp_e     aluOp;
        logic       isMul;
    } ctrl_t;

    // ungated write requests, condUnit applies the condition
    typedef struct packed {
        logic       regW;
        logic       memW;
        logic       nextPc;
        logic       branch;
        logic [1:0] flagW; // {N/Z, C/V}
    } writeReq_t;

    typedef struct packed {
        word_t addr;
        word_t writeData;
        logic  write;
    } memBus_t;

endpackage

// File: rtl/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic              clk,
    input  logic              writeEn,
    input  armPkg::regAddr_t  ra1,
    input  armPkg::regAddr_t  ra2,
    input  armPkg::regAddr_t  wa,
    input  armPkg::word_t     wd,
    input  armPkg::word_t     r15,
    output armPkg::word_t     rd1,
    output armPkg::word_t     rd2
);
    import armPkg::*;

    word_t regs [0:14]; // r0..r14, r15 lives in the PC

    always_ff @(posedge clk) begin
        if (writeEn && wa != regPc) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == regPc) ? r15 : regs[ra1];
    assign rd2 = (ra2 == regPc) ? r15 : regs[ra2];

endmodule

// File: rtl/armDecoder.sv
`timescale 1ns/100ps

module armDecoder (
    input  logic               clk,
    input  logic               reset,
    input  armPkg::word_t      instr,
    output armPkg::ctrl_t      ctrl,
    output armPkg::writeReq_t  writeReq
);
    import armPkg::*;

    fsmState_e state;
    fsmState_e nextState;
    logic [1:0] op;
    logic sBit;
    logic isMul;
    logic aluActive;
    logic branchState;
    aluOp_e aluSel;

    assign op = instr[27:26];
    assign sBit = instr[20];
    // register form only, an immediate may carry 1001 in bits 7:4
    assign isMul = (op == opDataProc) && !instr[25] && (instr[7:4] == mulPattern);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            stFetch: nextState = stDecode;
            stDecode: begin
                case (op)
                    opDataProc: nextState = instr[25] ? stExecuteI : stExecuteR;
                    opMemory:   nextState = stMemAdr;
                    opBranch:   nextState = stBranch;
                    default:    nextState = stFetch; // coprocessor space, skip
                endcase
            end
            stMemAdr: nextState = instr[20] ? stMemRd : stMemWr; // L bit
            stMemRd: nextState = stMemWb;
            stExecuteR, stExecuteI: nextState = stAluWb;
            default: nextState = stFetch;
        endcase
    end

    always_comb begin
        if (isMul) begin
            aluSel = aluMul;
        end else begin
            case (instr[24:21])
                cmdAdd:  aluSel = aluAdd;
                cmdSub:  aluSel = aluSub;
                cmdAnd:  aluSel = aluAnd;
                cmdOrr:  aluSel = aluOrr;
                cmdEor:  aluSel = aluEor;
                default: aluSel = aluAdd;
            endcase
        end
    end

    always_comb begin
        ctrl = '0;
        writeReq = '0;
        aluActive = 1'b0;
        branchState = 1'b0;
        ctrl.immSrc = op;
        ctrl.regSrc = {op == opMemory, op == opBranch}; // Rd for stores, r15 for B
        ctrl.isMul = isMul;
        ctrl.aluOp = aluAdd;
        case (state)
            stFetch: begin
                ctrl.irWrite = 1'b1;
                ctrl.resultSrc = 2'b10;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'b10; // PC + 4
                writeReq.nextPc = 1'b1;
            end
            stDecode: begin
                // PC + 8 becomes the r15 read value
                ctrl.resultSrc = 2'b10;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'b10;
            end
            stExecuteR: aluActive = 1'b1;
            stExecuteI: begin
                aluActive = 1'b1;
                ctrl.aluSrcB = 2'b01;
            end
            stAluWb: writeReq.regW = 1'b1;
            stMemAdr: ctrl.aluSrcB = 2'b01;
            stMemRd: ctrl.adrSrc = 1'b1;
            stMemWb: begin
                ctrl.resultSrc = 2'b01;
                writeReq.regW = 1'b1;
            end
            stMemWr: begin
                ctrl.adrSrc = 1'b1;
                writeReq.memW = 1'b1;
            end
            stBranch: begin
                branchState = 1'b1;
                ctrl.resultSrc = 2'b10;
                ctrl.aluSrcB = 2'b01;
            end
            default: ;
        endcase
        if (aluActive) begin
            ctrl.aluOp = aluSel;
            writeReq.flagW[1] = sBit;
            writeReq.flagW[0] = sBit && (aluSel == aluAdd || aluSel == aluSub);
        end
        // writes to r15 go through the PC
        writeReq.branch = branchState || (writeReq.regW && instr[15:12] == regPc);
    end

endmodule

// File: rtl/condUnit.sv
`timescale 1ns/100ps

module condUnit (
    input  logic               clk,
    input  logic               reset,
    input  armPkg::cond_e      cond,
    input  armPkg::aluFlags_t  aluFlags,
    input  armPkg::writeReq_t  writeReq,
    output logic               regWrite,
    output logic               memWrite,
    output logic               pcWrite
);
    import armPkg::*;

    aluFlags_t flags;
    logic condEx;
    logic condExReg;
    logic ge;
    logic [1:0] flagWrite;

    assign ge = (flags.neg == flags.overflow);

    always_comb begin
        case (cond)
            condEq:  condEx = flags.zero;
            condNe:  condEx = !flags.zero;
            condCs:  condEx = flags.carry;
            condCc:  condEx = !flags.carry;
            condMi:  condEx = flags.neg;
            condPl:  condEx = !flags.neg;
            condVs:  condEx = flags.overflow;
            condVc:  condEx = !flags.overflow;
            condHi:  condEx = flags.carry && !flags.zero;
            condLs:  condEx = !(flags.carry && !flags.zero);
            condGe:  condEx = ge;
            condLt:  condEx = !ge;
            condGt:  condEx = !flags.zero && ge;
            condLe:  condEx = !(!flags.zero && ge);
            condAl:  condEx = 1'b1;
            default: condEx = 1'b0;
        endcase
    end

    assign flagWrite = writeReq.flagW & {2{condEx}};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
            condExReg <= 1'b0;
        end else begin
            condExReg <= condEx;
            if (flagWrite[1]) begin
                flags.neg <= aluFlags.neg;
                flags.zero <= aluFlags.zero;
            end
            if (flagWrite[0]) begin // only ADD/SUB ask for this half
                flags.carry <= aluFlags.carry;
                flags.overflow <= aluFlags.overflow;
            end
        end
    end

    assign regWrite = writeReq.regW && condExReg;
    assign memWrite = writeReq.memW && condExReg;
    assign pcWrite = writeReq.nextPc || (writeReq.branch && condExReg);

endmodule

// File: rtl/armExecute.sv
`timescale 1ns/100ps

module armExecute (
    input  logic               clk,
    input  logic               reset,
    input  armPkg::word_t      instr,
    input  armPkg::ctrl_t      ctrl,
    input  armPkg::word_t      pc,
    input  armPkg::word_t      result,
    input  logic               regWrite,
    output armPkg::word_t      writeData,
    output armPkg::word_t      aluResult,
    output armPkg::word_t      aluOut,
    output armPkg::aluFlags_t  aluFlags
);
    import armPkg::*;

    regAddr_t ra1;
    regAddr_t ra2;
    regAddr_t wa;
    word_t rd1;
    word_t rd2;
    word_t srcAReg;
    word_t extImm;
    word_t srcA;
    word_t srcB;
    word_t bIn;
    logic [32:0] sum;
    logic isSub;
    logic addSub;
    logic overflow;

    // MUL puts Rd in 19:16 and reads Rm, Rs
    always_comb begin
        ra1 = ctrl.isMul ? instr[3:0] : instr[19:16];
        ra2 = ctrl.isMul ? instr[11:8] : instr[3:0];
        if (ctrl.regSrc[0]) begin
            ra1 = regPc;
        end
        if (ctrl.regSrc[1]) begin
            ra2 = instr[15:12]; // store data
        end
    end

    assign wa = ctrl.isMul ? instr[19:16] : instr[15:12];

    regFile rf (
        .clk     (clk),
        .writeEn (regWrite),
        .ra1     (ra1),
        .ra2     (ra2),
        .wa      (wa),
        .wd      (result),
        .r15     (result),
        .rd1     (rd1),
        .rd2     (rd2)
    );

    always_comb begin
        case (ctrl.immSrc)
            2'b00:   extImm = {24'd0, instr[7:0]};
            2'b01:   extImm = {20'd0, instr[11:0]};
            2'b10:   extImm = {{6{instr[23]}}, instr[23:0], 2'b00}; // word offset
            default: extImm = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            srcAReg <= '0;
            writeData <= '0;
            aluOut <= '0;
        end else begin
            srcAReg <= rd1;
            writeData <= rd2;
            aluOut <= aluResult;
        end
    end

    assign srcA = ctrl.aluSrcA ? pc : srcAReg;

    always_comb begin
        case (ctrl.aluSrcB)
            2'b00:   srcB = writeData;
            2'b01:   srcB = extImm;
            default: srcB = 32'd4;
        endcase
    end

    // one adder for both, subtract as a + ~b + 1
    assign isSub = (ctrl.aluOp == aluSub);
    assign addSub = isSub || (ctrl.aluOp == aluAdd);
    assign bIn = isSub ? ~srcB : srcB;
    assign sum = {1'b0, srcA} + {1'b0, bIn} + {32'd0, isSub};
    assign overflow = !(srcA[31] ^ bIn[31]) && (srcA[31] ^ sum[31]);

    always_comb begin
        case (ctrl.aluOp)
            aluAnd:  aluResult = srcA & srcB;
            aluOrr:  aluResult = srcA | srcB;
            aluEor:  aluResult = srcA ^ srcB;
            aluMul:  aluResult = srcA * srcB; // low word only
            default: aluResult = sum[31:0];
        endcase
    end

    assign aluFlags = '{
        neg:      aluResult[31],
        zero:     (aluResult == '0),
        carry:    addSub && sum[32],
        overflow: addSub && overflow
    };

endmodule

// File: rtl/armResult.sv
`timescale 1ns/100ps

module armResult (
    input  logic           clk,
    input  logic           reset,
    input  armPkg::ctrl_t  ctrl,
    input  logic           pcWrite,
    input  armPkg::word_t  readData,
    input  armPkg::word_t  aluResult,
    input  armPkg::word_t  aluOut,
    output armPkg::word_t  instr,
    output armPkg::word_t  pc,
    output armPkg::word_t  result,
    output armPkg::word_t  addr
);
    import armPkg::*;

    word_t data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
            instr <= '0;
        end else begin
            if (pcWrite) begin
                pc <= result; // next PC is always the result
            end
            if (ctrl.irWrite) begin
                instr <= readData;
            end
        end
    end

    always_ff @(posedge clk) begin
        data <= readData; // load data, used in memWb
    end

    always_comb begin
        case (ctrl.resultSrc)
            2'b00:   result = aluOut;
            2'b01:   result = data;
            default: result = aluResult;
        endcase
    end

    assign addr = ctrl.adrSrc ? result : pc;

endmodule

// File: rtl/armCore.sv
`timescale 1ns/100ps

module armCore (
    input  logic             clk,
    input  logic             reset,
    output armPkg::memBus_t  memBus,
    input  armPkg::word_t    readData
);
    import armPkg::*;

    word_t instr;
    word_t pc;
    word_t result;
    word_t addr;
    word_t writeData;
    word_t aluResult;
    word_t aluOut;
    aluFlags_t aluFlags;
    ctrl_t ctrl;
    writeReq_t writeReq;
    logic regWrite;
    logic memWrite;
    logic pcWrite;

    armDecoder decoder (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .ctrl     (ctrl),
        .writeReq (writeReq)
    );

    condUnit conds (
        .clk      (clk),
        .reset    (reset),
        .cond     (cond_e'(instr[31:28])),
        .aluFlags (aluFlags),
        .writeReq (writeReq),
        .regWrite (regWrite),
        .memWrite (memWrite),
        .pcWrite  (pcWrite)
    );

    armExecute execute (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .ctrl      (ctrl),
        .pc        (pc),
        .result    (result),
        .regWrite  (regWrite),
        .writeData (writeData),
        .aluResult (aluResult),
        .aluOut    (aluOut),
        .aluFlags  (aluFlags)
    );

    armResult resultPath (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .pcWrite   (pcWrite),
        .readData  (readData),
        .aluResult (aluResult),
        .aluOut    (aluOut),
        .instr     (instr),
        .pc        (pc),
        .result    (result),
        .addr      (addr)
    );

    assign memBus = '{addr: addr, writeData: writeData, write: memWrite};

endmodule

// File: tb/armCoreTb.sv
`timescale 1ns/100ps

module armCoreTb;
    import armPkg::*;

    localparam word_t markerAddr = 32'h3fc;
    localparam word_t loadAddr = 32'h300;
    localparam logic [3:0] al = 4'he;

    logic clk;
    logic reset;
    memBus_t memBus;
    word_t readData;

    word_t mem [0:255];
    logic expValid [0:255];
    word_t expValue [0:255];
    logic seen [0:255];

    word_t lcgState = 32'hab4d7098;
    int progIdx = 0;
    int cycleLimit = 0;
    int runCycles = 0;
    int errors = 0;
    int storesSeen = 0;
    int missing = 0;
    logic [7:0] wIdx;
    logic inRange;
    logic atMarker;

    armCore i_dut (
        .clk      (clk),
        .reset    (reset),
        .memBus   (memBus),
        .readData (readData)
    );

    always #2 clk = ~clk;

    assign wIdx = memBus.addr[9:2];
    assign inRange = (memBus.addr[31:10] == '0) && (memBus.addr[1:0] == 2'b00);
    assign atMarker = (memBus.addr == markerAddr);
    assign readData = mem[wIdx]; // same-cycle answer

    function automatic word_t nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic word_t dataImm(logic [3:0] cond, logic [3:0] cmd, logic s,
                                      regAddr_t rn, regAddr_t rd, logic [7:0] imm);
        return {cond, 2'b00, 1'b1, cmd, s, rn, rd, 4'h0, imm};
    endfunction

    function automatic word_t dataReg(logic [3:0] cond, logic [3:0] cmd, logic s,
                                      regAddr_t rn, regAddr_t rd, regAddr_t rm);
        return {cond, 2'b00, 1'b0, cmd, s, rn, rd, 8'h00, rm};
    endfunction

    function automatic word_t mulInstr(regAddr_t rd, regAddr_t rm, regAddr_t rs);
        return {al, 6'b000000, 2'b00, rd, 4'h0, rs, 4'b1001, rm};
    endfunction

    // P=1 U=1, immediate offset
    function automatic word_t memInstr(logic [3:0] cond, logic load, regAddr_t rn,
                                       regAddr_t rd, logic [11:0] offset);
        return {cond, 2'b01, 4'b0110, 1'b0, load, rn, rd, offset};
    endfunction

    function automatic word_t branchInstr(logic [3:0] cond, logic [23:0] offset);
        return {cond, 4'b1010, offset};
    endfunction

    // flags of x - y, then the condition
    function automatic logic passesAfterSub(cond_e cond, word_t x, word_t y);
        word_t diff;
        logic n;
        logic z;
        logic v;
        diff = x - y;
        n = diff[31];
        z = (diff == '0);
        v = (x[31] != y[31]) && (diff[31] != x[31]);
        case (cond)
            condEq:  return z;
            condNe:  return !z;
            condGe:  return n == v;
            condLt:  return n != v;
            default: return 1'b1;
        endcase
    endfunction

    task automatic emit(word_t w);
        mem[progIdx] = w;
        progIdx++;
    endtask

    task automatic storeIf(logic [3:0] cond, regAddr_t rd, word_t addr, word_t value,
                           logic expected);
        emit(memInstr(cond, 1'b0, 4'd0, rd, addr[11:0]));
        if (expected) begin
            expValid[addr[9:2]] = 1'b1;
            expValue[addr[9:2]] = value;
        end
    endtask

    task automatic buildProgram();
        word_t rnd;
        word_t aw;
        word_t bw;
        word_t cw;
        word_t prod;
        word_t loadWord;
        logic [63:0] square;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        cond_e checks [0:3];
        rnd = nextRandom();
        a = rnd[31:24];
        b = rnd[23:16];
        c = rnd[15:8];
        if (b == a) begin
            b = a ^ 8'h01;
        end
        aw = {24'd0, a};
        bw = {24'd0, b};
        cw = {24'd0, c};
        prod = aw * bw;
        loadWord = nextRandom();
        square = {32'd0, loadWord} * {32'd0, loadWord}; // full product, low word kept
        mem[loadAddr[9:2]] = loadWord;
        checks = '{condEq, condNe, condGe, condLt};

        emit(dataImm(al, cmdAnd, 1'b0, 4'd0, 4'd0, 8'h00)); // r0 = 0 even from X
        emit(dataImm(al, cmdOrr, 1'b0, 4'd0, 4'd1, a));
        emit(dataImm(al, cmdOrr, 1'b0, 4'd0, 4'd2, b));
        emit(dataReg(al, cmdAdd, 1'b0, 4'd1, 4'd3, 4'd2));
        storeIf(al, 4'd3, 32'h200, aw + bw, 1'b1);
        emit(dataReg(al, cmdSub, 1'b0, 4'd1, 4'd4, 4'd2));
        storeIf(al, 4'd4, 32'h204, aw - bw, 1'b1);
        emit(dataReg(al, cmdAnd, 1'b0, 4'd1, 4'd5, 4'd2));
        storeIf(al, 4'd5, 32'h208, aw & bw, 1'b1);
        emit(dataReg(al, cmdOrr, 1'b0, 4'd1, 4'd6, 4'd2));
        storeIf(al, 4'd6, 32'h20c, aw | bw, 1'b1);
        emit(dataReg(al, cmdEor, 1'b0, 4'd1, 4'd7, 4'd2));
        storeIf(al, 4'd7, 32'h210, aw ^ bw, 1'b1);
        emit(dataImm(al, cmdAdd, 1'b0, 4'd1, 4'd8, c));
        storeIf(al, 4'd8, 32'h214, aw + cw, 1'b1);
        emit(dataImm(al, cmdSub, 1'b0, 4'd2, 4'd8, c));
        storeIf(al, 4'd8, 32'h218, bw - cw, 1'b1);
        emit(dataImm(al, cmdEor, 1'b0, 4'd1, 4'd8, c));
        storeIf(al, 4'd8, 32'h21c, aw ^ cw, 1'b1);

        emit(mulInstr(4'd9, 4'd1, 4'd2));
        storeIf(al, 4'd9, 32'h220, prod, 1'b1);

        emit(memInstr(al, 1'b1, 4'd0, 4'd11, loadAddr[11:0]));
        storeIf(al, 4'd11, 32'h228, loadWord, 1'b1);
        emit(mulInstr(4'd10, 4'd11, 4'd11)); // wraps past 32 bits
        storeIf(al, 4'd10, 32'h224, square[31:0], 1'b1);

        // equal operands
        emit(dataReg(al, cmdSub, 1'b1, 4'd1, 4'd12, 4'd1));
        for (int k = 0; k < 4; k++) begin
            storeIf(checks[k], 4'd3, 32'h230 + 4 * k, aw + bw,
                    passesAfterSub(checks[k], aw, aw));
        end
        emit(dataReg(al, cmdAdd, 1'b0, 4'd1, 4'd13, 4'd2)); // nonzero, no S
        storeIf(condEq, 4'd3, 32'h240, aw + bw, 1'b1);

        // unequal operands
        emit(dataReg(al, cmdSub, 1'b1, 4'd1, 4'd12, 4'd2));
        for (int k = 0; k < 4; k++) begin
            storeIf(checks[k], 4'd3, 32'h250 + 4 * k, aw + bw,
                    passesAfterSub(checks[k], aw, bw));
        end
        emit(dataReg(al, cmdAdd, 1'b0, 4'd0, 4'd13, 4'd0)); // zero, no S
        storeIf(condNe, 4'd3, 32'h260, aw + bw, 1'b1);

        emit(branchInstr(al, 24'd0)); // skips one word
        storeIf(al, 4'd3, 32'h270, aw + bw, 1'b0);
        emit(branchInstr(condEq, 24'd0)); // Z clear here
        storeIf(al, 4'd3, 32'h274, aw + bw, 1'b1);

        storeIf(al, 4'd0, markerAddr, '0, 1'b0);
        emit(branchInstr(al, 24'hfffffe));
    endtask

    task automatic reportAndFinish();
        for (int i = 0; i < 256; i++) begin
            if (expValid[i] && !seen[i]) begin
                missing++;
                $display("expected store to address %h never arrived", i * 4);
            end
        end
        $display("stores checked %0d, missing %0d, errors %0d", storesSeen, missing, errors);
        if (errors == 0 && missing == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // checks sample at the falling edge, between drive and write
    resetQuiet: assert property (@(negedge clk) (runCycles == 0) |-> !memBus.write)
        else begin
            errors++;
            $display("a store was issued during reset or right after it, at %0t", $time);
        end

    firstFetch: assert property (@(negedge clk)
                                 (!reset && runCycles == 0) |-> memBus.addr == '0)
        else begin
            errors++;
            $display("mismatch at %0t: first fetch address %h, expected 0", $time,
                     memBus.addr);
        end

    storeKnown: assert property (@(negedge clk) disable iff (reset)
                                 (memBus.write && !atMarker)
                                 |-> (inRange && expValid[wIdx] && !seen[wIdx]))
        else begin
            errors++;
            if (inRange && expValid[wIdx]) begin
                $display("address %h was stored to a second time at %0t", memBus.addr,
                         $time);
            end else begin
                $display("unexpected store to address %h at %0t", memBus.addr, $time);
            end
        end

    storeValue: assert property (@(negedge clk) disable iff (reset)
                                 (memBus.write && inRange && expValid[wIdx])
                                 |-> memBus.writeData == expValue[wIdx])
        else begin
            errors++;
            $display("mismatch at %0t: store to %h wrote %h, expected %h", $time,
                     memBus.addr, memBus.writeData, expValue[wIdx]);
        end

    always @(posedge clk) begin
        if (memBus.write && inRange) begin
            mem[wIdx] <= memBus.writeData;
            seen[wIdx] <= 1'b1;
            if (expValid[wIdx]) begin
                storesSeen <= storesSeen + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            runCycles <= runCycles + 1;
            if (memBus.write && atMarker) begin
                reportAndFinish();
            end else if (runCycles >= cycleLimit) begin
                errors++;
                $display("timeout, the program did not reach the end marker in %0d cycles",
                         cycleLimit);
                reportAndFinish();
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hf000_0000 | i; // cond never, harmless if fetched
            expValid[i] = 1'b0;
            expValue[i] = '0;
            seen[i] = 1'b0;
        end
        buildProgram();
        cycleLimit = 5 * progIdx + 50;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: verilog.f
rtl/armPkg.sv
rtl/regFile.sv
rtl/armDecoder.sv
rtl/condUnit.sv
rtl/armExecute.sv
rtl/armResult.sv
rtl/armCore.sv
tb/armCoreTb.sv

// File: Bender.yml
package:
  name: arm_core

sources:
  - rtl/armPkg.sv
  - rtl/regFile.sv
  - rtl/armDecoder.sv
  - rtl/condUnit.sv
  - rtl/armExecute.sv
  - rtl/armResult.sv
  - rtl/armCore.sv
  - target: simulation
    files:
      - tb/armCoreTb.sv
